/* tb.f */
+incdir+design
+incdir+test
design/dc_addr_pkg.sv
design/dc_msg_pkg.sv
design/tq_ifs.sv
design/tq_match.sv
design/tq_entry_array.sv
design/lu_req_mux.sv
design/lu_rsp_decode.sv
design/d_cache_tq.sv
test/tb_d_cache_tq.sv

/* Makefile */
TOP := tb_d_cache_tq

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and pass only if the run reports TEST OK"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f tb.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf obj_dir

/* test/tb_table.svh */
`ifndef TB_TABLE_SVH
`define TB_TABLE_SVH

// Each row gives the core request, fill, lookup response and ready
// followed by the expected lookup request and core response
task automatic load_table;
    t_cl la;
    t_cl lb;
    t_cl lc;
    t_cl fd;
    t_cl dm;
    t_cl ge;
    t_cl em;
    t_cl lh;
    t_lu_rsp wm;
    la = 128'h0A000003_0A000002_0A000001_0A000000;
    lb = 128'h0B000003_0B000002_0B000001_0B000000;
    lc = 128'h0C000003_0C000002_0C000001_0C000000;
    fd = 128'h0F000003_0F000002_0F000001_0F000000;
    // Fill data of line 0x0400 with words one and three written by the core
    dm = 128'hDDDD0003_0F000002_DDDD0001_0F000000;
    ge = 128'h0E000003_0E000002_0E000001_0E000000;
    em = 128'h0E000003_0E000002_0E000001_EEEE0000;
    lh = 128'h11000003_11000002_11000001_11000000;

    // ==============================
    // Reads take the lowest idle entries and hits free them
    // ==============================
    add_row(rd_req(20'h01000, 5'd1), '0, '0, 1'b1,
            core_lu(RD_LU, 20'h01000, '0, 2'd0, 5'd1, 1'b0), '0);
    add_row(rd_req(20'h02004, 5'd2), '0, '0, 1'b1,
            core_lu(RD_LU, 20'h02004, '0, 2'd1, 5'd2, 1'b0), '0);
    add_row('0, '0, pipe_rsp(RD_LU, HIT, 20'h01008, la, 2'd0, 5'd1, 1'b1), 1'b1,
            '0, word_back(32'h0A000002, 20'h01008, 5'd1));
    // Entry zero was freed by the hit, so it is reused here
    add_row(rd_req(20'h03000, 5'd3), '0, '0, 1'b1,
            core_lu(RD_LU, 20'h03000, '0, 2'd0, 5'd3, 1'b0), '0);
    add_row('0, '0, pipe_rsp(RD_LU, HIT, 20'h02004, lb, 2'd1, 5'd2, 1'b1), 1'b1,
            '0, word_back(32'h0B000001, 20'h02004, 5'd2));
    add_row('0, '0, pipe_rsp(RD_LU, HIT, 20'h03000, lc, 2'd0, 5'd3, 1'b1), 1'b1,
            '0, word_back(32'h0C000000, 20'h03000, 5'd3));

    // ==============================
    // Write miss, write merge and fill
    // ==============================
    add_row(wr_req(20'h04004, 32'hDDDD0001, 5'd4), '0, '0, 1'b1,
            core_lu(WR_LU, 20'h04004, 32'hDDDD0001, 2'd0, 5'd4, 1'b0), '0);
    add_row(wr_req(20'h0400C, 32'hDDDD0003, 5'd5), '0,
            pipe_rsp(WR_LU, MISS, 20'h04004, '0, 2'd0, 5'd4, 1'b0), 1'b1,
            core_lu(WR_LU, 20'h0400C, 32'hDDDD0003, 2'd0, 5'd5, 1'b1), '0);
    add_row('0, fill_of(20'h04000, fd), '0, 1'b1, '0, '0);
    add_row('0, '0, '0, 1'b1, fill_lu(20'h04004, dm, 2'd0, 5'd4, 1'b0, 1'b1), '0);

    // ==============================
    // Read merged into a line waiting for its fill
    // ==============================
    add_row(wr_req(20'h05000, 32'hEEEE0000, 5'd6), '0, '0, 1'b1,
            core_lu(WR_LU, 20'h05000, 32'hEEEE0000, 2'd0, 5'd6, 1'b0), '0);
    add_row('0, '0, pipe_rsp(WR_LU, MISS, 20'h05000, '0, 2'd0, 5'd6, 1'b0), 1'b1, '0, '0);
    add_row(rd_req(20'h05008, 5'd7), '0, '0, 1'b1,
            core_lu(RD_LU, 20'h05008, '0, 2'd0, 5'd7, 1'b1), '0);
    // The line already carries a read, so this one takes a new entry
    add_row(rd_req(20'h0500C, 5'd8), fill_of(20'h05000, ge), '0, 1'b1,
            core_lu(RD_LU, 20'h0500C, '0, 2'd1, 5'd8, 1'b0), '0);
    add_row('0, '0, '0, 1'b1, fill_lu(20'h05008, em, 2'd0, 5'd7, 1'b1, 1'b1), '0);
    add_row('0, '0, pipe_rsp(FILL_LU, FILL, 20'h05008, em, 2'd0, 5'd7, 1'b1), 1'b1,
            '0, word_back(32'h0E000002, 20'h05008, 5'd7));
    add_row('0, '0, pipe_rsp(RD_LU, HIT, 20'h0500C, em, 2'd1, 5'd8, 1'b1), 1'b1,
            '0, word_back(32'h0E000003, 20'h0500C, 5'd8));

    // ==============================
    // Full queue
    // ==============================
    add_row(rd_req(20'h10000, 5'd9), '0, '0, 1'b1,
            core_lu(RD_LU, 20'h10000, '0, 2'd0, 5'd9, 1'b0), '0);
    add_row(rd_req(20'h11000, 5'd10), '0,
            pipe_rsp(RD_LU, MISS, 20'h10000, '0, 2'd0, 5'd9, 1'b1), 1'b1,
            core_lu(RD_LU, 20'h11000, '0, 2'd1, 5'd10, 1'b0), '0);
    add_row(rd_req(20'h12000, 5'd11), '0,
            pipe_rsp(RD_LU, MISS, 20'h11000, '0, 2'd1, 5'd10, 1'b1), 1'b1,
            core_lu(RD_LU, 20'h12000, '0, 2'd2, 5'd11, 1'b0), '0);
    add_row(rd_req(20'h13000, 5'd12), '0,
            pipe_rsp(RD_LU, MISS, 20'h12000, '0, 2'd2, 5'd11, 1'b1), 1'b0,
            core_lu(RD_LU, 20'h13000, '0, 2'd3, 5'd12, 1'b0), '0);
    add_row('0, '0, pipe_rsp(RD_LU, MISS, 20'h13000, '0, 2'd3, 5'd12, 1'b1), 1'b0, '0, '0);
    add_row('0, fill_of(20'h11000, lh), '0, 1'b0, '0, '0);
    add_row('0, '0, '0, 1'b0, fill_lu(20'h11000, lh, 2'd1, 5'd10, 1'b1, 1'b0), '0);
    add_row('0, '0, '0, 1'b1, '0, '0);
    add_row('0, '0, pipe_rsp(FILL_LU, FILL, 20'h11000, lh, 2'd1, 5'd10, 1'b1), 1'b1,
            '0, word_back(32'h11000000, 20'h11000, 5'd10));

    // ==============================
    // Hit with a write still in the pipe
    // ==============================
    // The last idle entry is taken, so the queue is full again
    add_row(rd_req(20'h14000, 5'd13), '0, '0, 1'b0,
            core_lu(RD_LU, 20'h14000, '0, 2'd1, 5'd13, 1'b0), '0);
    wm = pipe_rsp(RD_LU, HIT, 20'h14000, la, 2'd1, 5'd13, 1'b1);
    wm.wr_match_in_pipe = 1'b1;
    add_row('0, '0, wm, 1'b0, '0, word_back(32'h0A000000, 20'h14000, 5'd13));
    // The entry stays in lookup-core, so no entry frees up
    add_row('0, '0, '0, 1'b0, '0, '0);
    add_row('0, '0, pipe_rsp(RD_LU, HIT, 20'h14000, la, 2'd1, 5'd13, 1'b1), 1'b0,
            '0, word_back(32'h0A000000, 20'h14000, 5'd13));
    add_row('0, '0, '0, 1'b1, '0, '0);
endtask

`endif

/* test/tb_d_cache_tq.sv */
`timescale 1ns/1ps

module tb_d_cache_tq
    import dc_addr_pkg::*;
    import dc_msg_pkg::*;
();

    // One clock cycle of stimulus and the responses expected in it
    typedef struct {
        t_core_req core_req;
        t_fill_rsp fill_rsp;
        t_lu_rsp   lu_rsp;
        logic      ready;
        t_lu_req   lu_req;
        t_core_rsp core_rsp;
    } t_row;

    logic      clk;
    logic      reset;
    t_core_req core_req;
    logic      ready;
    t_core_rsp core_rsp;
    t_fill_rsp fill_rsp;
    t_lu_req   lu_req;
    t_lu_rsp   lu_rsp;

    t_row rows[$];
    int   wait_cycles;

    d_cache_tq u_d_cache_tq (
        .clk      (clk),
        .reset    (reset),
        .core_req (core_req),
        .ready    (ready),
        .core_rsp (core_rsp),
        .fill_rsp (fill_rsp),
        .lu_req   (lu_req),
        .lu_rsp   (lu_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==============================
    // Row builders
    // ==============================
    function automatic t_core_req rd_req(t_address addr, t_reg_id reg_id);
        t_core_req r;
        r = '0;
        r.valid   = 1'b1;
        r.opcode  = RD_OP;
        r.address = addr;
        r.reg_id  = reg_id;
        return r;
    endfunction

    function automatic t_core_req wr_req(t_address addr, t_word data, t_reg_id reg_id);
        t_core_req r;
        r = rd_req(addr, reg_id);
        r.opcode = WR_OP;
        r.data   = data;
        return r;
    endfunction

    function automatic t_fill_rsp fill_of(t_address addr, t_cl line);
        t_fill_rsp r;
        r.valid   = 1'b1;
        r.address = addr;
        r.data    = line;
        return r;
    endfunction

    // Response of stage three as the pipe model returns it
    function automatic t_lu_rsp pipe_rsp(t_lu_op op, t_lu_result res, t_address addr,
                                         t_cl line, t_tq_id id, t_reg_id reg_id, logic rd);
        t_lu_rsp r;
        r = '0;
        r.valid         = 1'b1;
        r.lu_op         = op;
        r.lu_result     = res;
        r.address       = addr;
        r.cl_data       = line;
        r.tq_id         = id;
        r.reg_id        = reg_id;
        r.rd_indication = rd;
        return r;
    endfunction

    // A core lookup takes its indications from the opcode
    function automatic t_lu_req core_lu(t_lu_op op, t_address addr, t_word data,
                                        t_tq_id id, t_reg_id reg_id, logic mb);
        t_lu_req r;
        r = '0;
        r.valid         = 1'b1;
        r.lu_op         = op;
        r.address       = addr;
        r.data          = data;
        r.tq_id         = id;
        r.reg_id        = reg_id;
        r.rd_indication = (op == RD_LU);
        r.wr_indication = (op == WR_LU);
        r.mb_hit_cancel = mb;
        return r;
    endfunction

    function automatic t_lu_req fill_lu(t_address addr, t_cl line, t_tq_id id,
                                        t_reg_id reg_id, logic rd, logic wr);
        t_lu_req r;
        r = '0;
        r.valid         = 1'b1;
        r.lu_op         = FILL_LU;
        r.address       = addr;
        r.cl_data       = line;
        r.tq_id         = id;
        r.reg_id        = reg_id;
        r.rd_indication = rd;
        r.wr_indication = wr;
        return r;
    endfunction

    function automatic t_core_rsp word_back(t_word data, t_address addr, t_reg_id reg_id);
        t_core_rsp r;
        r.valid   = 1'b1;
        r.data    = data;
        r.address = addr;
        r.reg_id  = reg_id;
        return r;
    endfunction

    function automatic void add_row(t_core_req req, t_fill_rsp fill, t_lu_rsp rsp,
                                    logic rdy, t_lu_req exp_lu, t_core_rsp exp_rsp);
        t_row r;
        r.core_req = req;
        r.fill_rsp = fill;
        r.lu_rsp   = rsp;
        r.ready    = rdy;
        r.lu_req   = exp_lu;
        r.core_rsp = exp_rsp;
        rows.push_back(r);
    endfunction

    `include "tb_table.svh"

    // ==============================
    // Compare tasks
    // ==============================
    task automatic report_mismatch(string name, string exp_s, string act_s);
        $display("Fail at %0d ns: %s expected %s got %s", $time, name, exp_s, act_s);
        $display("TEST FAILED");
        $fatal(1, "Mismatch on %s", name);
    endtask

    task automatic check_ready(logic exp, logic act);
        if (act !== exp)
            report_mismatch("ready", $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_lu_req(t_lu_req exp, t_lu_req act);
        if (act !== exp)
            report_mismatch("lu_req", $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    // Data of an invalid response is a don't care
    task automatic check_core_rsp(t_core_rsp exp, t_core_rsp act);
        if (act.valid !== exp.valid)
            report_mismatch("core_rsp.valid", $sformatf("%b", exp.valid),
                            $sformatf("%b", act.valid));
        else if (exp.valid && act !== exp)
            report_mismatch("core_rsp", $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    // Watchdog for the whole run
    initial begin
        #50000;
        $display("Simulation ran past its time limit");
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        reset    = 1'b1;
        core_req = '0;
        fill_rsp = '0;
        lu_rsp   = '0;
        load_table();

        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        // Ready must come up with every entry idle
        wait_cycles = 0;
        while (ready !== 1'b1) begin
            if (wait_cycles == 20) begin
                $display("Ready stayed low after reset");
                $display("TEST FAILED");
                $fatal(1, "Reset wait timed out");
            end
            @(posedge clk);
            wait_cycles++;
        end
        check_lu_req('0, lu_req);
        check_core_rsp('0, core_rsp);

        // Drive 1 ns after the edge and compare 2 ns before the next one
        foreach (rows[i]) begin
            @(posedge clk);
            #1;
            core_req = rows[i].core_req;
            fill_rsp = rows[i].fill_rsp;
            lu_rsp   = rows[i].lu_rsp;
            #7;
            check_ready(rows[i].ready, ready);
            check_lu_req(rows[i].lu_req, lu_req);
            check_core_rsp(rows[i].core_rsp, core_rsp);
        end

        @(posedge clk);
        #1;
        core_req = '0;
        fill_rsp = '0;
        lu_rsp   = '0;
        $display("TEST OK");
        $finish;
    end

endmodule

/* design/d_cache_tq.sv */
`timescale 1ns/1ps

module d_cache_tq
    import dc_msg_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    // Core side
    input  var t_core_req core_req,
    output logic          ready,
    output t_core_rsp     core_rsp,
    // Memory fill
    input  var t_fill_rsp fill_rsp,
    // Lookup pipe, request in stage one and response from stage three
    output t_lu_req       lu_req,
    input  var t_lu_rsp   lu_rsp
);

    tq_view_if view ();
    tq_cmd_if  cmd ();
    lu_evt_if  evt ();

    // ==============================
    // Stage one
    // ==============================
    tq_match u_tq_match (
        .core_req (core_req),
        .view     (view),
        .cmd      (cmd),
        .ready    (ready)
    );

    lu_req_mux u_lu_req_mux (
        .core_req (core_req),
        .view     (view),
        .cmd      (cmd),
        .lu_req   (lu_req)
    );

    // Entry state is the only storage in the queue
    tq_entry_array u_tq_entry_array (
        .clk      (clk),
        .reset    (reset),
        .core_req (core_req),
        .fill_rsp (fill_rsp),
        .cmd      (cmd),
        .evt      (evt),
        .view     (view)
    );

    // Stage three
    lu_rsp_decode u_lu_rsp_decode (
        .lu_rsp   (lu_rsp),
        .evt      (evt),
        .core_rsp (core_rsp)
    );

endmodule

/* design/lu_rsp_decode.sv */
`timescale 1ns/1ps
`include "dc_params.svh"

module lu_rsp_decode
    import dc_addr_pkg::*;
    import dc_msg_pkg::*;
(
    input  var t_lu_rsp lu_rsp,
    lu_evt_if.source    evt,
    output t_core_rsp   core_rsp
);

    t_word_offset rsp_word_offset;
    logic         rd_hit;
    logic         fill_with_rd;

    // Every stage three response is an event for the entry it names
    assign evt.valid    = lu_rsp.valid;
    assign evt.tq_id    = lu_rsp.tq_id;
    assign evt.result   = lu_rsp.lu_result;
    assign evt.wr_match = lu_rsp.wr_match_in_pipe;

    // Data reaches the core on a direct read hit or with the fill of a merged read
    assign rd_hit       = lu_rsp.valid && (lu_rsp.lu_op == RD_LU) && (lu_rsp.lu_result == HIT);
    assign fill_with_rd = lu_rsp.valid && (lu_rsp.lu_op == FILL_LU) && lu_rsp.rd_indication;

    assign rsp_word_offset = lu_rsp.address[`DC_BYTE_OFF_W +: `DC_WORD_OFF_W];

    assign core_rsp.valid   = rd_hit || fill_with_rd;
    assign core_rsp.data    = lu_rsp.cl_data[rsp_word_offset];
    assign core_rsp.address = lu_rsp.address;
    assign core_rsp.reg_id  = lu_rsp.reg_id;

endmodule

/* design/lu_req_mux.sv */
`timescale 1ns/1ps
`include "dc_params.svh"

module lu_req_mux
    import dc_addr_pkg::*;
    import dc_msg_pkg::*;
(
    input  var t_core_req core_req,
    tq_view_if.viewer     view,
    tq_cmd_if.sink        cmd,
    output t_lu_req       lu_req
);

    // Core requests own the pipe slot; a ready fill only fills an empty slot
    always_comb begin
        lu_req = '0;
        if (core_req.valid) begin
            lu_req.valid         = 1'b1;
            lu_req.lu_op         = (core_req.opcode == WR_OP) ? WR_LU : RD_LU;
            lu_req.address       = core_req.address;
            lu_req.data          = core_req.data;
            lu_req.tq_id         = cmd.tq_id;
            lu_req.reg_id        = core_req.reg_id;
            lu_req.rd_indication = (core_req.opcode == RD_OP);
            lu_req.wr_indication = (core_req.opcode == WR_OP);
            // Merged requests ride an entry that already owns the line
            lu_req.mb_hit_cancel = cmd.mb_hit;
        end else if (cmd.fill_go) begin
            lu_req.valid         = 1'b1;
            lu_req.lu_op         = FILL_LU;
            // Word offset points at the attached read, if there is one
            lu_req.address       = {view.cl_address[cmd.fill_id],
                                    view.word_offset[cmd.fill_id],
                                    {`DC_BYTE_OFF_W{1'b0}}};
            lu_req.cl_data       = view.mb_data[cmd.fill_id];
            lu_req.tq_id         = cmd.fill_id;
            lu_req.reg_id        = view.reg_id[cmd.fill_id];
            lu_req.rd_indication = view.rd_ind[cmd.fill_id];
            lu_req.wr_indication = view.wr_ind[cmd.fill_id];
        end
    end

endmodule

/* design/tq_entry_array.sv */
`timescale 1ns/1ps
`include "dc_params.svh"

module tq_entry_array
    import dc_addr_pkg::*;
    import dc_msg_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  var t_core_req core_req,
    input  var t_fill_rsp fill_rsp,
    tq_cmd_if.sink        cmd,
    lu_evt_if.sink        evt,
    tq_view_if.owner      view
);

    t_tq_state    [`DC_NUM_TQ_ENTRY-1:0] state;
    t_tq_state    [`DC_NUM_TQ_ENTRY-1:0] next_state;
    t_cl_address  [`DC_NUM_TQ_ENTRY-1:0] cl_address;
    t_cl_address  [`DC_NUM_TQ_ENTRY-1:0] next_cl_address;
    t_word_offset [`DC_NUM_TQ_ENTRY-1:0] word_offset;
    t_word_offset [`DC_NUM_TQ_ENTRY-1:0] next_word_offset;
    t_reg_id      [`DC_NUM_TQ_ENTRY-1:0] reg_id;
    t_reg_id      [`DC_NUM_TQ_ENTRY-1:0] next_reg_id;
    logic         [`DC_NUM_TQ_ENTRY-1:0] rd_ind;
    logic         [`DC_NUM_TQ_ENTRY-1:0] next_rd_ind;
    logic         [`DC_NUM_TQ_ENTRY-1:0] wr_ind;
    logic         [`DC_NUM_TQ_ENTRY-1:0] next_wr_ind;
    t_cl          [`DC_NUM_TQ_ENTRY-1:0] mb_data;
    t_cl          [`DC_NUM_TQ_ENTRY-1:0] next_mb_data;
    t_word_mask   [`DC_NUM_TQ_ENTRY-1:0] mb_mod;
    t_word_mask   [`DC_NUM_TQ_ENTRY-1:0] next_mb_mod;

    t_tq_vec      fill_hit;
    t_cl_address  req_cl_address;
    t_word_offset req_word_offset;
    t_cl_address  fill_cl_address;

    assign req_cl_address  = core_req.address[`DC_ADDR_W-1 -: `DC_CL_ADDR_W];
    assign req_word_offset = core_req.address[`DC_BYTE_OFF_W +: `DC_WORD_OFF_W];
    assign fill_cl_address = fill_rsp.address[`DC_ADDR_W-1 -: `DC_CL_ADDR_W];

    // Memory returns one line per miss, so the line address alone finds the waiter
    always_comb begin
        for (int i = 0; i < `DC_NUM_TQ_ENTRY; i++) begin
            fill_hit[i] = fill_rsp.valid &&
                          (state[i] == S_MB_WAIT_FILL) &&
                          (fill_cl_address == cl_address[i]);
        end
    end

    // ==============================
    // Per entry FSM and merge buffer
    // ==============================
    always_comb begin
        for (int i = 0; i < `DC_NUM_TQ_ENTRY; i++) begin
            next_state[i]       = state[i];
            next_cl_address[i]  = cl_address[i];
            next_word_offset[i] = word_offset[i];
            next_reg_id[i]      = reg_id[i];
            next_rd_ind[i]      = rd_ind[i];
            next_wr_ind[i]      = wr_ind[i];
            next_mb_data[i]     = mb_data[i];
            next_mb_mod[i]      = mb_mod[i];

            unique case (state[i])
                S_IDLE: begin
                    if (cmd.alloc[i])
                        next_state[i] = S_LU_CORE;
                end
                S_LU_CORE: begin
                    // A fill result here belongs to an older owner of the entry
                    if (evt.valid && (evt.tq_id == t_tq_id'(i))) begin
                        if (evt.result == HIT)
                            next_state[i] = evt.wr_match ? S_LU_CORE : S_IDLE;
                        else if (evt.result == MISS)
                            next_state[i] = S_MB_WAIT_FILL;
                    end
                end
                S_MB_WAIT_FILL: begin
                    if (fill_hit[i])
                        next_state[i] = S_MB_FILL_READY;
                end
                S_MB_FILL_READY: begin
                    if (cmd.fill_issue[i])
                        next_state[i] = S_IDLE;
                end
                default: begin
                    next_state[i] = state[i];
                end
            endcase

            // New entry starts with a clean merge buffer
            if (cmd.alloc[i]) begin
                next_cl_address[i]  = req_cl_address;
                next_word_offset[i] = req_word_offset;
                next_reg_id[i]      = core_req.reg_id;
                next_rd_ind[i]      = (core_req.opcode == RD_OP);
                next_wr_ind[i]      = (core_req.opcode == WR_OP);
                next_mb_data[i]     = '0;
                next_mb_mod[i]      = '0;
                if (core_req.opcode == WR_OP) begin
                    next_mb_data[i][req_word_offset] = core_req.data;
                    next_mb_mod[i][req_word_offset]  = 1'b1;
                end
            end

            // Read after write: the fill lookup will answer this read
            if (cmd.rd_hit[i]) begin
                next_rd_ind[i]      = 1'b1;
                next_word_offset[i] = req_word_offset;
                next_reg_id[i]      = core_req.reg_id;
            end

            // Write after write just overwrites its word in the buffer
            if (cmd.wr_hit[i]) begin
                next_wr_ind[i]                   = 1'b1;
                next_mb_data[i][req_word_offset] = core_req.data;
                next_mb_mod[i][req_word_offset]  = 1'b1;
            end

            // Fill goes in under the written words, including one written this cycle
            if (fill_hit[i]) begin
                for (int w = 0; w < `DC_WORDS_IN_CL; w++) begin
                    if (!next_mb_mod[i][w])
                        next_mb_data[i][w] = fill_rsp.data[w];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= {`DC_NUM_TQ_ENTRY{S_IDLE}};
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        cl_address  <= next_cl_address;
        word_offset <= next_word_offset;
        reg_id      <= next_reg_id;
        rd_ind      <= next_rd_ind;
        wr_ind      <= next_wr_ind;
        mb_data     <= next_mb_data;
        mb_mod      <= next_mb_mod;
    end

    assign view.state       = state;
    assign view.cl_address  = cl_address;
    assign view.word_offset = word_offset;
    assign view.reg_id      = reg_id;
    assign view.rd_ind      = rd_ind;
    assign view.wr_ind      = wr_ind;
    assign view.mb_data     = mb_data;

endmodule

/* design/tq_match.sv */
`timescale 1ns/1ps
`include "dc_params.svh"

module tq_match
    import dc_addr_pkg::*;
    import dc_msg_pkg::*;
(
    input  var t_core_req core_req,
    tq_view_if.viewer     view,
    tq_cmd_if.source      cmd,
    output logic          ready
);

    t_tq_vec     match;
    t_tq_vec     free_vec;
    t_tq_vec     fill_vec;
    t_tq_vec     first_free;
    t_tq_vec     first_fill;
    t_tq_vec     alloc_vec;
    t_cl_address req_cl_address;
    logic        mb_hit;

    // Encoded index of the lowest set bit, zero for an empty vector
    function automatic t_tq_id first_id(t_tq_vec vec);
        t_tq_id id;
        id = '0;
        for (int i = `DC_NUM_TQ_ENTRY - 1; i >= 0; i--) begin
            if (vec[i])
                id = t_tq_id'(i);
        end
        return id;
    endfunction

    assign req_cl_address = core_req.address[`DC_ADDR_W-1 -: `DC_CL_ADDR_W];

    // ==============================
    // Merge buffer compare
    // ==============================
    // An open entry accepts merges until a read has been attached to it
    // Only one entry tracks a given line, so at most one bit of match is set
    always_comb begin
        for (int i = 0; i < `DC_NUM_TQ_ENTRY; i++) begin
            free_vec[i] = (view.state[i] == S_IDLE);
            fill_vec[i] = (view.state[i] == S_MB_FILL_READY);
            match[i]    = core_req.valid &&
                          !free_vec[i] &&
                          !view.rd_ind[i] &&
                          (view.cl_address[i] == req_cl_address);
        end
    end

    assign mb_hit = |match;

    // Lowest set bit as a one-hot vector
    assign first_free = free_vec & (~free_vec + t_tq_vec'(1));
    assign first_fill = fill_vec & (~fill_vec + t_tq_vec'(1));

    // A request that misses the merge buffer takes the lowest idle entry
    assign alloc_vec = (core_req.valid && !mb_hit) ? first_free : '0;

    assign cmd.alloc  = alloc_vec;
    assign cmd.rd_hit = (core_req.opcode == RD_OP) ? match : '0;
    assign cmd.wr_hit = (core_req.opcode == WR_OP) ? match : '0;
    assign cmd.mb_hit = mb_hit;
    assign cmd.tq_id  = mb_hit ? first_id(match) : first_id(free_vec);

    // ==============================
    // Fill pick
    // ==============================
    // Fills only use the pipe when the core leaves the slot empty
    assign cmd.fill_go    = (|fill_vec) && !core_req.valid;
    assign cmd.fill_issue = cmd.fill_go ? first_fill : '0;
    assign cmd.fill_id    = first_id(fill_vec);

    // Full when no entry stays idle after this cycle's allocation
    assign ready = ~&(~free_vec | alloc_vec);

endmodule

/* design/tq_ifs.sv */
`timescale 1ns/1ps
`include "dc_params.svh"

// ==============================
// Entry view
// ==============================
// Registered contents of every queue entry, published by the entry array
interface tq_view_if import dc_addr_pkg::*, dc_msg_pkg::*; ();
    t_tq_state    [`DC_NUM_TQ_ENTRY-1:0] state;
    t_cl_address  [`DC_NUM_TQ_ENTRY-1:0] cl_address;
    t_word_offset [`DC_NUM_TQ_ENTRY-1:0] word_offset;
    t_reg_id      [`DC_NUM_TQ_ENTRY-1:0] reg_id;
    logic         [`DC_NUM_TQ_ENTRY-1:0] rd_ind;
    logic         [`DC_NUM_TQ_ENTRY-1:0] wr_ind;
    t_cl          [`DC_NUM_TQ_ENTRY-1:0] mb_data;

    modport owner  (output state, cl_address, word_offset, reg_id, rd_ind, wr_ind, mb_data);
    modport viewer (input  state, cl_address, word_offset, reg_id, rd_ind, wr_ind, mb_data);
endinterface

// ==============================
// Stage one decisions
// ==============================
// Vectors are one-hot per entry, ids are the matching encoded index
interface tq_cmd_if import dc_addr_pkg::*; ();
    t_tq_vec alloc;
    t_tq_vec rd_hit;
    t_tq_vec wr_hit;
    t_tq_vec fill_issue;
    t_tq_id  tq_id;
    logic    mb_hit;
    t_tq_id  fill_id;
    logic    fill_go;

    modport source (output alloc, rd_hit, wr_hit, fill_issue, tq_id, mb_hit, fill_id, fill_go);
    modport sink   (input  alloc, rd_hit, wr_hit, fill_issue, tq_id, mb_hit, fill_id, fill_go);
endinterface

// ==============================
// Stage three entry events
// ==============================
interface lu_evt_if import dc_addr_pkg::*, dc_msg_pkg::*; ();
    logic       valid;
    t_tq_id     tq_id;
    t_lu_result result;
    logic       wr_match;

    modport source (output valid, tq_id, result, wr_match);
    modport sink   (input  valid, tq_id, result, wr_match);
endinterface

/* design/dc_msg_pkg.sv */
package dc_msg_pkg;
    import dc_addr_pkg::*;

    typedef enum logic {
        RD_OP = 1'b0,
        WR_OP = 1'b1
    } t_opcode;

    // Kind of lookup sent down the pipe
    typedef enum logic [1:0] {
        NO_LU   = 2'b00,
        RD_LU   = 2'b01,
        WR_LU   = 2'b10,
        FILL_LU = 2'b11
    } t_lu_op;

    typedef enum logic [1:0] {
        HIT  = 2'b00,
        MISS = 2'b01,
        FILL = 2'b10
    } t_lu_result;

    // Life cycle of one queue entry
    typedef enum logic [1:0] {
        S_IDLE          = 2'b00,
        S_LU_CORE       = 2'b01,
        S_MB_WAIT_FILL  = 2'b10,
        S_MB_FILL_READY = 2'b11
    } t_tq_state;

    typedef struct packed {
        logic     valid;
        t_opcode  opcode;
        t_address address;
        t_word    data;
        t_reg_id  reg_id;
    } t_core_req;

    typedef struct packed {
        logic     valid;
        t_word    data;
        t_address address;
        t_reg_id  reg_id;
    } t_core_rsp;

    // Line returned by memory after a miss
    typedef struct packed {
        logic     valid;
        t_address address;
        t_cl      data;
    } t_fill_rsp;

    typedef struct packed {
        logic     valid;
        t_lu_op   lu_op;
        t_address address;
        t_word    data;
        t_cl      cl_data;
        t_tq_id   tq_id;
        t_reg_id  reg_id;
        logic     rd_indication;
        logic     wr_indication;
        logic     mb_hit_cancel;
    } t_lu_req;

    typedef struct packed {
        logic       valid;
        t_lu_op     lu_op;
        t_lu_result lu_result;
        t_address   address;
        t_cl        cl_data;
        t_tq_id     tq_id;
        t_reg_id    reg_id;
        logic       rd_indication;
        logic       wr_match_in_pipe;
    } t_lu_rsp;

endpackage

/* design/dc_addr_pkg.sv */
`include "dc_params.svh"

package dc_addr_pkg;

    // Full byte address as the core sees it
    typedef logic [`DC_ADDR_W-1:0]       t_address;

    // Tag and set bits, which name one cache line
    typedef logic [`DC_CL_ADDR_W-1:0]    t_cl_address;
    typedef logic [`DC_WORD_OFF_W-1:0]   t_word_offset;

    typedef logic [`DC_WORD_W-1:0]       t_word;

    // A line is kept word by word so a word offset can index it directly
    typedef logic [`DC_WORDS_IN_CL-1:0][`DC_WORD_W-1:0] t_cl;

    typedef logic [`DC_REG_ID_W-1:0]     t_reg_id;

    // Queue entry index, encoded and as a vector with one bit per entry
    typedef logic [`DC_TQ_ID_W-1:0]      t_tq_id;
    typedef logic [`DC_NUM_TQ_ENTRY-1:0] t_tq_vec;

    // One modified bit per word of the merge buffer
    typedef logic [`DC_WORDS_IN_CL-1:0]  t_word_mask;

endpackage

/* design/dc_params.svh */
`ifndef DC_PARAMS_SVH
`define DC_PARAMS_SVH

// Queue depth, one entry per outstanding line
`define DC_NUM_TQ_ENTRY 4

// Address and data widths of the core side
`define DC_ADDR_W       20
`define DC_WORD_W       32
`define DC_WORDS_IN_CL  4
`define DC_REG_ID_W     5

// Field split of a byte address: line address, word offset, byte offset
`define DC_BYTE_OFF_W   2
`define DC_WORD_OFF_W   2
`define DC_CL_ADDR_W    (`DC_ADDR_W - `DC_WORD_OFF_W - `DC_BYTE_OFF_W)

// Encoded entry index width
`define DC_TQ_ID_W      $clog2(`DC_NUM_TQ_ENTRY)

`endif
